/* Bender.yml */
package:
  name: lsu_axi

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/mem_access_align.sv
      - hdl/load_extract.sv
      - hdl/lsu_axi_master.sv
      - hdl/axi_sram.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/lsu_tb.sv

/* hdl/axi_sram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module axi_sram (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        awvalid,
    output logic                       awready,
    input  wire [`LSU_XLEN-1:0]        awaddr,
    input  wire [3:0]                  awid,
    input  wire [7:0]                  awlen,
    input  wire [2:0]                  awsize,
    input  wire [1:0]                  awburst,
    input  wire                        wvalid,
    output logic                       wready,
    input  wire [`LSU_XLEN-1:0]        wdata,
    input  wire [`LSU_STRB_W-1:0]      wstrb,
    input  wire                        wlast,
    output logic                       bvalid,
    input  wire                        bready,
    output logic [1:0]                 bresp,
    output logic [3:0]                 bid,
    input  wire                        arvalid,
    output logic                       arready,
    input  wire [`LSU_XLEN-1:0]        araddr,
    input  wire [3:0]                  arid,
    input  wire [7:0]                  arlen,
    input  wire [2:0]                  arsize,
    input  wire [1:0]                  arburst,
    output logic                       rvalid,
    input  wire                        rready,
    output logic [`LSU_XLEN-1:0]       rdata,
    output logic [1:0]                 rresp,
    output logic                       rlast,
    output logic [3:0]                 rid
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    lsu_pkg::sram_state_e state;

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
    logic [IDX_W-1:0]     idx_q;
    logic [3:0]           id_q;
    logic                 err_q;
    logic [`LSU_XLEN-1:0] rdata_q;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 aw_in_range;
    logic                 ar_in_range;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    assign aw_in_range = (awaddr[`LSU_XLEN-1:2] < `LSU_MEM_WORDS);
    assign ar_in_range = (araddr[`LSU_XLEN-1:2] < `LSU_MEM_WORDS);

    // Writes win when both address channels arrive together
    assign awready = (state == lsu_pkg::ss_idle);
    assign arready = (state == lsu_pkg::ss_idle) && !awvalid;
    assign wready  = (state == lsu_pkg::ss_wdata);
    assign bvalid  = (state == lsu_pkg::ss_bresp);
    assign rvalid  = (state == lsu_pkg::ss_rdata);

    assign bresp = err_q ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
    assign rresp = err_q ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
    assign bid   = id_q;
    assign rid   = id_q;
    assign rdata = rdata_q;
    assign rlast = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= lsu_pkg::ss_idle;
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                lsu_pkg::ss_idle: begin
                    if (aw_hs) begin
                        state <= lsu_pkg::ss_wdata;
                    end else if (ar_hs) begin
                        state <= lsu_pkg::ss_rdata;
                    end
                end
                lsu_pkg::ss_wdata: begin
                    if (w_hs) begin
                        state <= lsu_pkg::ss_bresp;
                        // Only strobed bytes of an in-range word change
                        for (int b = 0; b < `LSU_STRB_W; b++) begin
                            if (wstrb[b] && !err_q) begin
                                mem[idx_q][8*b +: 8] <= wdata[8*b +: 8];
                            end
                        end
                    end
                end
                lsu_pkg::ss_bresp: begin
                    if (bready) begin
                        state <= lsu_pkg::ss_idle;
                    end
                end
                lsu_pkg::ss_rdata: begin
                    if (rready) begin
                        state <= lsu_pkg::ss_idle;
                    end
                end
                default: begin
                    state <= lsu_pkg::ss_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            idx_q <= awaddr[IDX_W+1:2];
            id_q  <= awid;
            err_q <= !aw_in_range;
        end else if (ar_hs) begin
            idx_q   <= araddr[IDX_W+1:2];
            id_q    <= arid;
            err_q   <= !ar_in_range;
            rdata_q <= ar_in_range ? mem[araddr[IDX_W+1:2]] : '0;
        end
    end

    a_aw_single_beat: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> (awlen == 8'd0) && (awsize == 3'd2) && (awburst == 2'b01));

    a_ar_single_beat: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (arlen == 8'd0) && (arsize == 3'd2) && (arburst == 2'b01));

    a_w_last: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> wlast);

endmodule

`default_nettype wire

/* hdl/load_extract.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module load_extract (
    input  wire lsu_pkg::mem_op_e      op,
    input  wire [1:0]                  addr_lo,
    input  wire [`LSU_XLEN-1:0]        rdata,
    output logic [`LSU_XLEN-1:0]       load_value
);

    logic [`LSU_XLEN-1:0] shifted;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata >> {addr_lo, 3'b000};

    always_comb begin
        case (op)
            lsu_pkg::op_lb: begin
                load_value = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::op_lbu: begin
                load_value = {24'd0, shifted[7:0]};
            end
            lsu_pkg::op_lh: begin
                load_value = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::op_lhu: begin
                load_value = {16'd0, shifted[15:0]};
            end
            default: begin
                // Word loads are aligned, so nothing was shifted
                load_value = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/lsu_axi_master.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_axi_master (
    input  wire                        clk,
    input  wire                        rst,
    // Request from execute
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire lsu_pkg::mem_op_e      op,
    input  wire [`LSU_XLEN-1:0]        addr,
    input  wire [`LSU_XLEN-1:0]        wdata,
    // Result to writeback
    output logic                       out_valid,
    input  wire                        out_ready,
    output logic [`LSU_XLEN-1:0]       result,
    output logic                       fault,
    // Alignment and extraction
    output lsu_pkg::mem_op_e           op_q,
    output logic [1:0]                 addr_lo,
    output logic [`LSU_XLEN-1:0]       wdata_q,
    input  wire [`LSU_STRB_W-1:0]      strb,
    input  wire [`LSU_XLEN-1:0]        lane_data,
    input  wire                        misaligned,
    input  wire [`LSU_XLEN-1:0]        load_value,
    // AXI4 write address
    output logic                       awvalid,
    input  wire                        awready,
    output logic [`LSU_XLEN-1:0]       awaddr,
    output logic [3:0]                 awid,
    output logic [7:0]                 awlen,
    output logic [2:0]                 awsize,
    output logic [1:0]                 awburst,
    // AXI4 write data
    output logic                       wvalid,
    input  wire                        wready,
    output logic [`LSU_XLEN-1:0]       wdata_axi,
    output logic [`LSU_STRB_W-1:0]     wstrb,
    output logic                       wlast,
    // AXI4 write response
    input  wire                        bvalid,
    output logic                       bready,
    input  wire [1:0]                  bresp,
    input  wire [3:0]                  bid,
    // AXI4 read address
    output logic                       arvalid,
    input  wire                        arready,
    output logic [`LSU_XLEN-1:0]       araddr,
    output logic [3:0]                 arid,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    // AXI4 read data
    input  wire                        rvalid,
    output logic                       rready,
    input  wire [`LSU_XLEN-1:0]        rdata,
    input  wire [1:0]                  rresp,
    input  wire                        rlast,
    input  wire [3:0]                  rid
);

    lsu_pkg::lsu_state_e state;

    logic [`LSU_XLEN-1:0] addr_q;
    logic [`LSU_XLEN-1:0] result_q;
    logic                 fault_q;
    logic                 is_load;
    logic                 is_store;
    logic                 shortcut;

    assign addr_lo = addr_q[1:0];

    assign is_load = op_q inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                                  lsu_pkg::op_lbu, lsu_pkg::op_lhu};
    assign is_store = op_q inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};

    // Non-memory ops and misaligned accesses answer without touching the bus
    assign shortcut = !(is_load || is_store) || misaligned;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= lsu_pkg::st_idle;
        end else begin
            case (state)
                lsu_pkg::st_idle: begin
                    if (in_valid) begin
                        state <= lsu_pkg::st_addr;
                    end
                end
                lsu_pkg::st_addr: begin
                    if (shortcut) begin
                        if (out_ready) begin
                            state <= lsu_pkg::st_idle;
                        end
                    end else if (is_store && awready) begin
                        state <= lsu_pkg::st_data;
                    end else if (is_load && arready) begin
                        state <= lsu_pkg::st_resp;
                    end
                end
                lsu_pkg::st_data: begin
                    if (wready) begin
                        state <= lsu_pkg::st_resp;
                    end
                end
                lsu_pkg::st_resp: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state <= lsu_pkg::st_done;
                    end
                end
                lsu_pkg::st_done: begin
                    if (out_ready) begin
                        state <= lsu_pkg::st_idle;
                    end
                end
                default: begin
                    state <= lsu_pkg::st_idle;
                end
            endcase
        end
    end

    // Request and response capture
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (bvalid && bready) begin
            result_q <= '0;
            fault_q  <= (bresp != `LSU_RESP_OKAY);
        end
        if (rvalid && rready) begin
            result_q <= (rresp == `LSU_RESP_OKAY) ? load_value : '0;
            fault_q  <= (rresp != `LSU_RESP_OKAY);
        end
    end

    assign in_ready  = (state == lsu_pkg::st_idle);
    assign out_valid = (state == lsu_pkg::st_done) || (state == lsu_pkg::st_addr && shortcut);

    // Shortcut results come straight from the registered request
    assign result = (state == lsu_pkg::st_done) ? result_q :
                    (op_q == lsu_pkg::op_none) ? addr_q : '0;
    assign fault  = (state == lsu_pkg::st_done) ? fault_q : misaligned;

    assign awvalid = (state == lsu_pkg::st_addr) && is_store && !shortcut;
    assign arvalid = (state == lsu_pkg::st_addr) && is_load && !shortcut;
    assign wvalid  = (state == lsu_pkg::st_data);
    assign bready  = (state == lsu_pkg::st_resp) && is_store;
    assign rready  = (state == lsu_pkg::st_resp) && is_load;

    // Single word beats at the word-aligned address
    assign awaddr    = {addr_q[`LSU_XLEN-1:2], 2'b00};
    assign araddr    = {addr_q[`LSU_XLEN-1:2], 2'b00};
    assign awid      = `LSU_AXI_ID;
    assign arid      = `LSU_AXI_ID;
    assign awlen     = 8'd0;
    assign arlen     = 8'd0;
    assign awsize    = 3'd2;
    assign arsize    = 3'd2;
    assign awburst   = 2'b01;
    assign arburst   = 2'b01;
    assign wdata_axi = lane_data;
    assign wstrb     = strb;
    assign wlast     = 1'b1;

    a_aw_w_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && wvalid));

    a_result_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(fault));

    a_rdata_expected: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rready && rlast && (rid == `LSU_AXI_ID));

    a_bresp_expected: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bready && (bid == `LSU_AXI_ID));

endmodule

`default_nettype wire

/* hdl/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data path and address width
`define LSU_XLEN 32
`define LSU_STRB_W 4

// Single fixed transaction id on aw and ar
`define LSU_AXI_ID 4'd0

// AXI response encodings
`define LSU_RESP_OKAY 2'b00
`define LSU_RESP_SLVERR 2'b10

// Data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

`endif

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Memory operation decoded by the execute stage
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // Load/store master sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp,
        st_done
    } lsu_state_e;

    // Memory slave sequencing
    typedef enum logic [1:0] {
        ss_idle,
        ss_wdata,
        ss_bresp,
        ss_rdata
    } sram_state_e;

endpackage

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire lsu_pkg::mem_op_e      op,
    input  wire [`LSU_XLEN-1:0]        addr,
    input  wire [`LSU_XLEN-1:0]        wdata,
    output logic                       out_valid,
    input  wire                        out_ready,
    output logic [`LSU_XLEN-1:0]       result,
    output logic                       fault
);

    lsu_pkg::mem_op_e          op_q;
    logic [1:0]                addr_lo;
    logic [`LSU_XLEN-1:0]      wdata_q;
    logic [`LSU_STRB_W-1:0]    strb;
    logic [`LSU_XLEN-1:0]      lane_data;
    logic                      misaligned;
    logic [`LSU_XLEN-1:0]      load_value;

    // AXI4 between the master and the memory
    logic                      awvalid;
    logic                      awready;
    logic [`LSU_XLEN-1:0]      awaddr;
    logic [3:0]                awid;
    logic [7:0]                awlen;
    logic [2:0]                awsize;
    logic [1:0]                awburst;
    logic                      wvalid;
    logic                      wready;
    logic [`LSU_XLEN-1:0]      wdata_axi;
    logic [`LSU_STRB_W-1:0]    wstrb;
    logic                      wlast;
    logic                      bvalid;
    logic                      bready;
    logic [1:0]                bresp;
    logic [3:0]                bid;
    logic                      arvalid;
    logic                      arready;
    logic [`LSU_XLEN-1:0]      araddr;
    logic [3:0]                arid;
    logic [7:0]                arlen;
    logic [2:0]                arsize;
    logic [1:0]                arburst;
    logic                      rvalid;
    logic                      rready;
    logic [`LSU_XLEN-1:0]      rdata;
    logic [1:0]                rresp;
    logic                      rlast;
    logic [3:0]                rid;

    lsu_axi_master i_master (.*);

    mem_access_align i_align (
        .op         (op_q),
        .addr_lo    (addr_lo),
        .store_data (wdata_q),
        .strb       (strb),
        .lane_data  (lane_data),
        .misaligned (misaligned)
    );

    // Extraction sees the read word as it is returned on the r channel
    load_extract i_extract (
        .op         (op_q),
        .addr_lo    (addr_lo),
        .rdata      (rdata),
        .load_value (load_value)
    );

    axi_sram i_sram (
        .wdata (wdata_axi),
        .*
    );

endmodule

`default_nettype wire

/* hdl/mem_access_align.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module mem_access_align (
    input  wire lsu_pkg::mem_op_e      op,
    input  wire [1:0]                  addr_lo,
    input  wire [`LSU_XLEN-1:0]        store_data,
    output logic [`LSU_STRB_W-1:0]     strb,
    output logic [`LSU_XLEN-1:0]       lane_data,
    output logic                       misaligned
);

    logic is_byte;
    logic is_half;
    logic is_word;

    assign is_byte = op inside {lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb};
    assign is_half = op inside {lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh};
    assign is_word = op inside {lsu_pkg::op_lw, lsu_pkg::op_sw};

    // Halfwords need an even address, words a 4-byte boundary
    assign misaligned = (is_half && addr_lo[0]) || (is_word && (addr_lo != 2'b00));

    // Move the store data up to the addressed byte lane
    assign lane_data = store_data << {addr_lo, 3'b000};

    always_comb begin
        if (is_byte) begin
            strb = 4'b0001 << addr_lo;
        end else if (is_half) begin
            strb = 4'b0011 << addr_lo;
        end else if (is_word) begin
            strb = 4'b1111;
        end else begin
            strb = 4'b0000;
        end
    end

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_tb;

    localparam int wait_limit = 64;
    localparam int mem_bytes  = `LSU_MEM_WORDS * 4;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    lsu_pkg::mem_op_e       op;
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_XLEN-1:0]   wdata;
    logic                   out_valid;
    logic                   out_ready;
    logic [`LSU_XLEN-1:0]   result;
    logic                   fault;

    // Byte image of the data memory
    logic [7:0]             model_mem [mem_bytes];
    logic [31:0]            lfsr;
    int                     checks;
    int                     errors;

    lsu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .fault     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
        finish_run();
    endtask

    // Expected outcome from the access rules
    // Stores also update the byte image
    task automatic predict(input lsu_pkg::mem_op_e o, input logic [31:0] a, input logic [31:0] d,
                           output logic [31:0] exp_res, output logic exp_fault);
        int          size;
        logic        is_store;
        logic        is_signed;
        logic [31:0] v;
        size      = 4;
        is_store  = 1'b0;
        is_signed = 1'b0;
        v         = '0;
        exp_res   = '0;
        exp_fault = 1'b0;
        case (o)
            lsu_pkg::op_lb: begin
                size      = 1;
                is_signed = 1'b1;
            end
            lsu_pkg::op_lbu: size = 1;
            lsu_pkg::op_lh: begin
                size      = 2;
                is_signed = 1'b1;
            end
            lsu_pkg::op_lhu: size = 2;
            lsu_pkg::op_sb: begin
                size     = 1;
                is_store = 1'b1;
            end
            lsu_pkg::op_sh: begin
                size     = 2;
                is_store = 1'b1;
            end
            lsu_pkg::op_sw:  is_store = 1'b1;
            default:         size = 4;
        endcase
        if (o == lsu_pkg::op_none) begin
            exp_res = a;
        end else if ((a % size) != 0 || a >= mem_bytes) begin
            exp_fault = 1'b1;
        end else if (is_store) begin
            for (int i = 0; i < size; i++) begin
                model_mem[a + i] = d[8*i +: 8];
            end
        end else begin
            for (int i = 0; i < size; i++) begin
                v[8*i +: 8] = model_mem[a + i];
            end
            if (size == 1 && is_signed) begin
                v = {{24{v[7]}}, v[7:0]};
            end else if (size == 2 && is_signed) begin
                v = {{16{v[15]}}, v[15:0]};
            end
            exp_res = v;
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic issue_req(input lsu_pkg::mem_op_e req_op, input logic [31:0] req_addr,
                             input logic [31:0] req_data);
        int cnt;
        cnt      = 0;
        in_valid = 1'b1;
        op       = req_op;
        addr     = req_addr;
        wdata    = req_data;
        @(negedge clk);
        while (!in_ready) begin
            cnt++;
            if (cnt >= wait_limit) begin
                report_timeout("in_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        op       = lsu_pkg::op_none;
        addr     = '0;
        wdata    = '0;
    endtask

    // Holds out_ready low for hold cycles once out_valid shows up
    task automatic get_result(input int hold, output logic [31:0] res, output logic f);
        int          cnt;
        logic [31:0] held_result;
        logic        held_fault;
        cnt = 0;
        @(negedge clk);
        while (!out_valid) begin
            cnt++;
            if (cnt >= wait_limit) begin
                report_timeout("out_valid");
            end
            @(negedge clk);
        end
        held_result = result;
        held_fault  = fault;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check("out_valid", out_valid, 1'b1);
            check("result", result, held_result);
            check("fault", fault, held_fault);
            check("in_ready", in_ready, 1'b0);
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        @(negedge clk);
        check("out_valid", out_valid, 1'b1);
        res = result;
        f   = fault;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        @(negedge clk);
        check("in_ready", in_ready, 1'b1);
        check("out_valid", out_valid, 1'b0);
        @(posedge clk);
        #1;
    endtask

    task automatic do_access(input lsu_pkg::mem_op_e o, input logic [31:0] a,
                             input logic [31:0] d, input int hold);
        logic [31:0] exp_res;
        logic        exp_fault;
        logic [31:0] res;
        logic        f;
        predict(o, a, d, exp_res, exp_fault);
        issue_req(o, a, d);
        get_result(hold, res, f);
        check($sformatf("result %s 0x%08h", o.name(), a), res, exp_res);
        check($sformatf("fault %s 0x%08h", o.name(), a), f, exp_fault);
    endtask

    task automatic end_test(input string name, input int start_errors);
        $display("%-16s done, %0d errors", name, errors - start_errors);
    endtask

    task automatic load_all_lanes(input logic [31:0] base);
        for (int k = 0; k < 4; k++) begin
            do_access(lsu_pkg::op_lb, base + k, '0, 0);
            do_access(lsu_pkg::op_lbu, base + k, '0, 0);
        end
        for (int k = 0; k < 4; k += 2) begin
            do_access(lsu_pkg::op_lh, base + k, '0, 0);
            do_access(lsu_pkg::op_lhu, base + k, '0, 0);
        end
        do_access(lsu_pkg::op_lw, base, '0, 0);
    endtask

    task automatic test_word_rw();
        int          e0;
        logic [31:0] a;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(8) << 2;
            do_access(lsu_pkg::op_sw, a, rand_bits(32), 0);
            do_access(lsu_pkg::op_lw, a, '0, 0);
        end
        end_test("test_word_rw", e0);
    endtask

    task automatic test_sub_word();
        int          e0;
        logic [31:0] base;
        e0   = errors;
        base = rand_bits(8) << 2;
        // Both sign polarities in every byte and halfword
        do_access(lsu_pkg::op_sw, base, 32'h80ff7f01, 0);
        load_all_lanes(base);
        for (int k = 0; k < 4; k++) begin
            do_access(lsu_pkg::op_sb, base + k, rand_bits(32), 0);
            load_all_lanes(base);
        end
        do_access(lsu_pkg::op_sh, base + 2, rand_bits(32), 0);
        do_access(lsu_pkg::op_sh, base, rand_bits(32), 0);
        load_all_lanes(base);
        end_test("test_sub_word", e0);
    endtask

    task automatic test_misaligned();
        int e0;
        e0 = errors;
        do_access(lsu_pkg::op_sw, 32'h100, 32'h11223344, 0);
        do_access(lsu_pkg::op_lh, 32'h101, '0, 0);
        do_access(lsu_pkg::op_lhu, 32'h103, '0, 0);
        do_access(lsu_pkg::op_lw, 32'h102, '0, 0);
        do_access(lsu_pkg::op_sh, 32'h101, 32'haaaaaaaa, 0);
        do_access(lsu_pkg::op_sw, 32'h103, 32'hbbbbbbbb, 0);
        do_access(lsu_pkg::op_sw, 32'h102, 32'hcccccccc, 0);
        do_access(lsu_pkg::op_lw, 32'h100, '0, 0);
        end_test("test_misaligned", e0);
    endtask

    task automatic test_out_of_range();
        int e0;
        e0 = errors;
        do_access(lsu_pkg::op_sw, 32'h0, 32'hcafef00d, 0);
        // Index bits of 0x400 match word 0, which must stay untouched
        do_access(lsu_pkg::op_sw, 32'h400, 32'hdeadbeef, 0);
        do_access(lsu_pkg::op_lw, 32'h400, '0, 0);
        do_access(lsu_pkg::op_lb, 32'h405, '0, 0);
        do_access(lsu_pkg::op_sb, 32'h801, 32'h5a, 0);
        do_access(lsu_pkg::op_sh, 32'h40000002, 32'h1234, 0);
        do_access(lsu_pkg::op_lhu, 32'h80000000, '0, 0);
        do_access(lsu_pkg::op_lw, 32'h0, '0, 0);
        end_test("test_out_of_range", e0);
    endtask

    task automatic test_none();
        int e0;
        e0 = errors;
        do_access(lsu_pkg::op_none, 32'h3, 32'h0, 0);
        for (int i = 0; i < 4; i++) begin
            do_access(lsu_pkg::op_none, rand_bits(32), rand_bits(32), 0);
        end
        end_test("test_none", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        do_access(lsu_pkg::op_sw, 32'h40, rand_bits(32), 5);
        do_access(lsu_pkg::op_lw, 32'h40, '0, 6);
        do_access(lsu_pkg::op_lb, 32'h43, '0, 2);
        do_access(lsu_pkg::op_none, 32'h1234, '0, 4);
        do_access(lsu_pkg::op_lw, 32'h41, '0, 3);
        do_access(lsu_pkg::op_lw, 32'h800, '0, 5);
        end_test("test_backpressure", e0);
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        op        = lsu_pkg::op_none;
        addr      = '0;
        wdata     = '0;
        out_ready = 1'b0;
        lfsr      = 32'd97983;
        checks    = 0;
        errors    = 0;
        for (int i = 0; i < mem_bytes; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        test_word_rw();
        test_sub_word();
        test_misaligned();
        test_out_of_range();
        test_none();
        test_backpressure();
        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/mem_access_align.sv
hdl/load_extract.sv
hdl/lsu_axi_master.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
sim/lsu_tb.sv
